//--- hw/lsu_pkg.sv
package lsu_pkg;

    // ------------------------------------------------------------------
    // widths and sizes
    localparam int XLEN       = 32;
    localparam int ROB_DEPTH  = 64;
    localparam int ROB_ID_W   = $clog2(ROB_DEPTH);
    localparam int IQ_SIZE    = 8;
    localparam int IQ_PTR_W   = $clog2(IQ_SIZE);
    // free count needs one more bit to hold IQ_SIZE itself
    localparam int IQ_CNT_W   = IQ_PTR_W + 1;
    localparam int REG_COUNT  = 2;
    localparam int CDB_COUNT  = 2;
    localparam int DMEM_WORDS = 256;
    localparam int DMEM_IDX_W = $clog2(DMEM_WORDS);
    localparam int STRB_W     = XLEN / 8;

    // operand slots
    localparam int OP_WDATA = 0;
    localparam int OP_BASE  = 1;

    // access size codes
    localparam logic [1:0] MSIZE_B = 2'd0;
    localparam logic [1:0] MSIZE_H = 2'd1;
    localparam logic [1:0] MSIZE_W = 2'd2;

    typedef logic [XLEN-1:0]     word_t;
    typedef logic [ROB_ID_W-1:0] rob_id_t;

    // ------------------------------------------------------------------
    // dispatch side
    typedef struct packed {
        logic       inst_valid;
        logic       wreg;
        rob_id_t    wreg_id;
        logic       wmem;
        logic       msigned;
        logic [1:0] msize;
        word_t      imm;
    } decode_info_t;

    typedef struct packed {
        word_t   data;
        rob_id_t tag;
        logic    valid;
    } operand_t;

    typedef struct packed {
        decode_info_t                 di;
        operand_t [REG_COUNT-1:0]     opnd;
    } disp_slot_t;

    typedef struct packed {
        logic    valid;
        rob_id_t rob_id;
        word_t   data;
    } cdb_t;

    // ------------------------------------------------------------------
    // memory side
    typedef struct packed {
        rob_id_t     rob_id;
        logic        wreg;
        logic        wmem;
        logic        msigned;
        logic [1:0]  msize;
        word_t       vaddr;
        word_t       wdata;
        logic [STRB_W-1:0] strb;
        logic        misalign;
    } lsu_req_t;

    typedef struct packed {
        rob_id_t rob_id;
        logic    wreg;
        word_t   wdata;
        logic    exc;
        word_t   badva;
    } result_t;

endpackage

//--- hw/iq_entry.sv
module iq_entry import lsu_pkg::*; (
    input  logic                      clk,
    input  logic                      rst_i,
    input  logic                      flush_i,
    input  logic                      init_i,
    input  disp_slot_t                slot_i,
    input  cdb_t  [CDB_COUNT-1:0]     cdb_i,
    input  logic                      select_i,
    output logic                      ready_o,
    output decode_info_t              di_o,
    output word_t [REG_COUNT-1:0]     data_o
);

    logic                       busy_q;
    decode_info_t               di_q;
    operand_t [REG_COUNT-1:0]   opnd_q;
    operand_t [REG_COUNT-1:0]   opnd_d;
    logic     [REG_COUNT-1:0]   opnd_ok;

    // fill a missing operand from the broadcast ports, port 0 has priority
    function automatic operand_t snoop(operand_t op, cdb_t [CDB_COUNT-1:0] cdb);
        operand_t res;
        res = op;
        if (!op.valid) begin
            for (int p = CDB_COUNT - 1; p >= 0; p--) begin
                if (cdb[p].valid && cdb[p].rob_id == op.tag) begin
                    res.data  = cdb[p].data;
                    res.valid = 1'b1;
                end
            end
        end
        return res;
    endfunction

    // ------------------------------------------------------------------
    // operand capture
    always_comb begin
        for (int r = 0; r < REG_COUNT; r++) begin
            // a new slot also sees the CDB of its own dispatch cycle
            opnd_d[r] = snoop(init_i ? slot_i.opnd[r] : opnd_q[r], cdb_i);
        end
    end

    always_ff @(posedge clk) begin
        if (rst_i || flush_i) begin
            busy_q <= 1'b0;
        end else if (init_i) begin
            busy_q <= 1'b1;
        end else if (select_i) begin
            busy_q <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        opnd_q <= opnd_d;
        if (init_i) begin
            di_q <= slot_i.di;
        end
    end

    // ------------------------------------------------------------------
    // outputs
    always_comb begin
        for (int r = 0; r < REG_COUNT; r++) begin
            opnd_ok[r] = opnd_q[r].valid;
            data_o[r]  = opnd_q[r].data;
        end
    end

    assign ready_o = busy_q && (&opnd_ok);
    assign di_o    = di_q;

endmodule

//--- hw/lsu_iq.sv
module lsu_iq import lsu_pkg::*; (
    input  logic                      clk,
    input  logic                      rst_i,
    input  logic                      flush_i,

    // dispatch
    input  disp_slot_t [1:0]          disp_i,
    input  logic       [1:0]          choose_i,
    output logic                      disp_ready_o,

    // result broadcast
    input  cdb_t  [CDB_COUNT-1:0]     cdb_i,

    // issue towards the address stage
    input  logic                      iss_ready_i,
    output logic                      iss_valid_o,
    output decode_info_t              iss_di_o,
    output word_t [REG_COUNT-1:0]     iss_data_o
);

    logic [IQ_PTR_W-1:0]    head_q;
    logic [IQ_PTR_W-1:0]    tail_q;
    logic [IQ_PTR_W-1:0]    tail_nx;
    logic [IQ_CNT_W-1:0]    free_q;
    logic [IQ_CNT_W-1:0]    free_d;

    logic [1:0]             disp_take;
    logic [1:0]             n_disp;
    disp_slot_t             slot_first;
    logic                   iss_accept;
    logic                   issue;

    logic         [IQ_SIZE-1:0]                 entry_ready;
    logic         [IQ_SIZE-1:0]                 entry_init;
    logic         [IQ_SIZE-1:0]                 entry_select;
    disp_slot_t   [IQ_SIZE-1:0]                 entry_slot;
    decode_info_t [IQ_SIZE-1:0]                 entry_di;
    word_t        [IQ_SIZE-1:0][REG_COUNT-1:0]  entry_data;

    // ------------------------------------------------------------------
    // pointers and free count
    assign disp_take = choose_i & {2{disp_ready_o}};
    assign n_disp    = {1'b0, disp_take[0]} + {1'b0, disp_take[1]};
    assign tail_nx   = tail_q + 1'b1;

    // only the head may leave, one per cycle
    assign iss_accept = !iss_valid_o || iss_ready_i;
    assign issue      = entry_ready[head_q] && iss_accept;

    assign free_d = free_q - IQ_CNT_W'(n_disp) + IQ_CNT_W'(issue);

    always_ff @(posedge clk) begin
        if (rst_i || flush_i) begin
            head_q       <= '0;
            tail_q       <= '0;
            free_q       <= IQ_CNT_W'(IQ_SIZE);
            disp_ready_o <= 1'b1;
        end else begin
            head_q       <= head_q + IQ_PTR_W'(issue);
            tail_q       <= tail_q + IQ_PTR_W'(n_disp);
            free_q       <= free_d;
            // room for a full two-wide dispatch next cycle
            disp_ready_o <= (free_d >= IQ_CNT_W'(2));
        end
    end

    // ------------------------------------------------------------------
    // slot routing and entries
    // single dispatch may come from either slot
    assign slot_first = disp_take[0] ? disp_i[0] : disp_i[1];

    for (genvar i = 0; i < IQ_SIZE; i++) begin : g_entry
        always_comb begin
            entry_init[i]   = 1'b0;
            entry_slot[i]   = slot_first;
            entry_select[i] = issue && (head_q == IQ_PTR_W'(i));
            if (disp_take != 2'b00 && tail_q == IQ_PTR_W'(i)) begin
                entry_init[i] = 1'b1;
            end
            if (disp_take == 2'b11 && tail_nx == IQ_PTR_W'(i)) begin
                entry_init[i] = 1'b1;
                entry_slot[i] = disp_i[1];
            end
        end

        iq_entry u_entry (
            .clk      (clk),
            .rst_i    (rst_i),
            .flush_i  (flush_i),
            .init_i   (entry_init[i]),
            .slot_i   (entry_slot[i]),
            .cdb_i    (cdb_i),
            .select_i (entry_select[i]),
            .ready_o  (entry_ready[i]),
            .di_o     (entry_di[i]),
            .data_o   (entry_data[i])
        );
    end

    // ------------------------------------------------------------------
    // issue register
    always_ff @(posedge clk) begin
        if (rst_i || flush_i) begin
            iss_valid_o <= 1'b0;
        end else if (iss_accept) begin
            iss_valid_o <= entry_ready[head_q];
        end
    end

    always_ff @(posedge clk) begin
        if (issue) begin
            iss_di_o   <= entry_di[head_q];
            iss_data_o <= entry_data[head_q];
        end
    end

endmodule

//--- hw/lsu_agu.sv
module lsu_agu import lsu_pkg::*; (
    input  logic                      clk,
    input  logic                      rst_i,
    input  logic                      flush_i,

    input  logic                      iss_valid_i,
    input  decode_info_t              iss_di_i,
    input  word_t [REG_COUNT-1:0]     iss_data_i,
    output logic                      iss_ready_o,

    input  logic                      req_ready_i,
    output logic                      req_valid_o,
    output lsu_req_t                  req_o
);

    word_t              vaddr;
    logic               misalign;
    logic [STRB_W-1:0]  lanes;
    lsu_req_t           req_d;

    // ------------------------------------------------------------------
    // address, alignment and lanes
    assign vaddr = iss_data_i[OP_BASE] + iss_di_i.imm;

    always_comb begin
        case (iss_di_i.msize)
            MSIZE_B: begin
                misalign = 1'b0;
                lanes    = STRB_W'(1) << vaddr[1:0];
            end
            MSIZE_H: begin
                misalign = vaddr[0];
                lanes    = STRB_W'(3) << {vaddr[1], 1'b0};
            end
            default: begin
                misalign = (vaddr[1:0] != 2'b00);
                lanes    = '1;
            end
        endcase
    end

    always_comb begin
        req_d          = '0;
        req_d.rob_id   = iss_di_i.wreg_id;
        req_d.wreg     = iss_di_i.wreg;
        req_d.wmem     = iss_di_i.wmem;
        req_d.msigned  = iss_di_i.msigned;
        req_d.msize    = iss_di_i.msize;
        req_d.vaddr    = vaddr;
        req_d.misalign = misalign;
        // store data moved onto its byte lanes
        req_d.wdata    = iss_data_i[OP_WDATA] << {vaddr[1:0], 3'b000};
        req_d.strb     = (iss_di_i.wmem && !misalign) ? lanes : '0;
    end

    // ------------------------------------------------------------------
    // request register
    assign iss_ready_o = !req_valid_o || req_ready_i;

    always_ff @(posedge clk) begin
        if (rst_i || flush_i) begin
            req_valid_o <= 1'b0;
        end else if (iss_ready_o) begin
            req_valid_o <= iss_valid_i;
        end
    end

    always_ff @(posedge clk) begin
        if (iss_valid_i && iss_ready_o) begin
            req_o <= req_d;
        end
    end

endmodule

//--- hw/lsu_dmem.sv
module lsu_dmem import lsu_pkg::*; (
    input  logic                      clk,
    input  logic                      rst_i,
    input  logic                      flush_i,

    input  logic                      req_valid_i,
    input  lsu_req_t                  req_i,
    output logic                      req_ready_o,

    input  logic                      result_ready_i,
    output logic                      result_valid_o,
    output result_t                   result_o
);

    word_t                  mem [DMEM_WORDS];
    logic [DMEM_IDX_W-1:0]  word_idx;
    logic                   accept;
    word_t                  rd_word;
    word_t                  rd_shift;
    word_t                  ld_val;
    result_t                result_d;

    // addresses wrap on the RAM size
    assign word_idx    = req_i.vaddr[DMEM_IDX_W+1:2];
    assign req_ready_o = !result_valid_o || result_ready_i;
    assign accept      = req_valid_i && req_ready_o;

    // ------------------------------------------------------------------
    // RAM write, byte lanes only
    always_ff @(posedge clk) begin
        if (accept && !flush_i) begin
            for (int b = 0; b < STRB_W; b++) begin
                if (req_i.strb[b]) begin
                    mem[word_idx][8*b +: 8] <= req_i.wdata[8*b +: 8];
                end
            end
        end
    end

    // ------------------------------------------------------------------
    // load extraction
    assign rd_word  = mem[word_idx];
    assign rd_shift = rd_word >> {req_i.vaddr[1:0], 3'b000};

    always_comb begin
        case (req_i.msize)
            MSIZE_B: begin
                ld_val = req_i.msigned ? {{(XLEN-8){rd_shift[7]}}, rd_shift[7:0]}
                                       : {{(XLEN-8){1'b0}}, rd_shift[7:0]};
            end
            MSIZE_H: begin
                ld_val = req_i.msigned ? {{(XLEN-16){rd_shift[15]}}, rd_shift[15:0]}
                                       : {{(XLEN-16){1'b0}}, rd_shift[15:0]};
            end
            default: begin
                ld_val = rd_word;
            end
        endcase
    end

    always_comb begin
        result_d        = '0;
        result_d.rob_id = req_i.rob_id;
        result_d.wreg   = req_i.wreg;
        result_d.exc    = req_i.misalign;
        // stores and faulting accesses return no data
        result_d.wdata  = (req_i.wmem || req_i.misalign) ? '0 : ld_val;
        result_d.badva  = req_i.misalign ? req_i.vaddr : '0;
    end

    // ------------------------------------------------------------------
    // result register
    always_ff @(posedge clk) begin
        if (rst_i || flush_i) begin
            result_valid_o <= 1'b0;
        end else if (req_ready_o) begin
            result_valid_o <= req_valid_i;
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            result_o <= result_d;
        end
    end

endmodule

//--- hw/lsu_top.sv
module lsu_top import lsu_pkg::*; (
    input  logic                      clk,
    input  logic                      rst_i,
    input  logic                      flush_i,

    input  disp_slot_t [1:0]          disp_i,
    input  logic       [1:0]          choose_i,
    output logic                      disp_ready_o,

    input  cdb_t  [CDB_COUNT-1:0]     cdb_i,

    output result_t                   result_o,
    output logic                      result_valid_o,
    input  logic                      result_ready_i
);

    // queue to address stage
    logic                   iss_valid;
    logic                   iss_ready;
    decode_info_t           iss_di;
    word_t [REG_COUNT-1:0]  iss_data;

    // address stage to memory stage
    logic                   req_valid;
    logic                   req_ready;
    lsu_req_t               req;

    lsu_iq u_iq (
        .clk          (clk),
        .rst_i        (rst_i),
        .flush_i      (flush_i),
        .disp_i       (disp_i),
        .choose_i     (choose_i),
        .disp_ready_o (disp_ready_o),
        .cdb_i        (cdb_i),
        .iss_ready_i  (iss_ready),
        .iss_valid_o  (iss_valid),
        .iss_di_o     (iss_di),
        .iss_data_o   (iss_data)
    );

    lsu_agu u_agu (
        .clk          (clk),
        .rst_i        (rst_i),
        .flush_i      (flush_i),
        .iss_valid_i  (iss_valid),
        .iss_di_i     (iss_di),
        .iss_data_i   (iss_data),
        .iss_ready_o  (iss_ready),
        .req_ready_i  (req_ready),
        .req_valid_o  (req_valid),
        .req_o        (req)
    );

    lsu_dmem u_dmem (
        .clk            (clk),
        .rst_i          (rst_i),
        .flush_i        (flush_i),
        .req_valid_i    (req_valid),
        .req_i          (req),
        .req_ready_o    (req_ready),
        .result_ready_i (result_ready_i),
        .result_valid_o (result_valid_o),
        .result_o       (result_o)
    );

endmodule

//--- test/lsu_ref.svh
`ifndef LSU_REF_SVH
`define LSU_REF_SVH

// ----------------------------------------------------------------------
// shadow of the data RAM, updated in program order at dispatch
word_t ref_mem [DMEM_WORDS];

// low nbytes of raw, sign or zero extended
function automatic word_t ref_extend(word_t raw, int nbytes, logic msigned);
    word_t res;
    res = raw;
    for (int i = 8 * nbytes; i < XLEN; i++) begin
        res[i] = msigned ? raw[8*nbytes-1] : 1'b0;
    end
    return res;
endfunction

// expected result of one instruction, stores also update the shadow
function automatic result_t ref_exec(decode_info_t di, word_t op_wdata, word_t op_base);
    result_t res;
    word_t   va;
    word_t   w;
    int      idx;
    int      off;
    int      nb;
    res = '0;
    va  = op_base + di.imm;
    idx = int'(va[9:2]);
    off = int'(va[1:0]);
    w   = ref_mem[idx];
    case (di.msize)
        MSIZE_B: nb = 1;
        MSIZE_H: nb = 2;
        default: nb = 4;
    endcase
    res.rob_id = di.wreg_id;
    res.wreg   = di.wreg;
    // an access must sit on its own size boundary
    res.exc    = (off % nb) != 0;
    if (res.exc) begin
        res.badva = va;
    end else if (di.wmem) begin
        for (int b = 0; b < nb; b++) begin
            w[8*(off+b) +: 8] = op_wdata[8*b +: 8];
        end
        ref_mem[idx] = w;
    end else begin
        res.wdata = ref_extend(w >> (8 * off), nb, di.msigned);
    end
    return res;
endfunction

`endif

//--- test/tb_lsu_top.sv
module tb_lsu_top import lsu_pkg::*; ();

    localparam int N_INIT     = 16;
    localparam int N_SIZES    = 21;
    localparam int N_RAND     = 120;
    localparam int N_FLUSH    = 20;
    localparam int N_POST     = 24;
    localparam int MAX_CYCLES = 40 * (N_INIT + N_SIZES + N_RAND + N_FLUSH + N_POST);

    logic                   clk;
    logic                   rst_i;
    logic                   flush_i;
    disp_slot_t [1:0]       disp_i;
    logic       [1:0]       choose_i;
    logic                   disp_ready_o;
    cdb_t  [CDB_COUNT-1:0]  cdb_i;
    result_t                result_o;
    logic                   result_valid_o;
    logic                   result_ready_i;

    int          seed;
    int          cycles;
    rob_id_t     tag_ctr;
    logic        tag_en;
    logic        bp_en;
    disp_slot_t  pend_q[$];
    cdb_t        bcast_q[$];
    result_t     exp_q[$];

    `include "lsu_ref.svh"

    lsu_top dut (
        .clk            (clk),
        .rst_i          (rst_i),
        .flush_i        (flush_i),
        .disp_i         (disp_i),
        .choose_i       (choose_i),
        .disp_ready_o   (disp_ready_o),
        .cdb_i          (cdb_i),
        .result_o       (result_o),
        .result_valid_o (result_valid_o),
        .result_ready_i (result_ready_i)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    // ------------------------------------------------------------------
    // failure reporting and result compare
    task automatic fail_now(input string msg);
        $display("%s", msg);
        $display("TESTS FAILED");
        $fatal(1);
    endtask

    task automatic mismatch(input string name, input word_t e, input word_t a);
        fail_now($sformatf("ERR %s expected %h got %h", name, e, a));
    endtask

    task automatic check_result(input result_t exp, input result_t act);
        if (exp.rob_id !== act.rob_id) begin
            mismatch("result_o.rob_id", word_t'(exp.rob_id), word_t'(act.rob_id));
        end else if (exp.wreg !== act.wreg) begin
            mismatch("result_o.wreg", word_t'(exp.wreg), word_t'(act.wreg));
        end else if (exp.wdata !== act.wdata) begin
            mismatch("result_o.wdata", exp.wdata, act.wdata);
        end else if (exp.exc !== act.exc) begin
            mismatch("result_o.exc", word_t'(exp.exc), word_t'(act.exc));
        end else if (exp.badva !== act.badva) begin
            mismatch("result_o.badva", exp.badva, act.badva);
        end
    endtask

    initial begin
        forever begin
            @(posedge clk);
            if (flush_i) begin
                exp_q.delete();
            end else if (!rst_i && result_valid_o && result_ready_i) begin
                if (exp_q.size() == 0) begin
                    fail_now("a result arrived with no instruction outstanding");
                end else begin
                    check_result(exp_q.pop_front(), result_o);
                end
            end
        end
    end

    initial begin
        cycles = 0;
        while (cycles < MAX_CYCLES) begin
            @(posedge clk);
            cycles++;
        end
        $display("timeout: run did not finish within %0d cycles", MAX_CYCLES);
        $display("TESTS FAILED");
        $fatal(1);
    end

    // ------------------------------------------------------------------
    // stimulus
    function automatic void add_inst(logic wmem, logic [1:0] msize, logic msigned, word_t va);
        disp_slot_t s;
        s                     = '0;
        s.di.inst_valid       = 1'b1;
        s.di.wreg             = !wmem;
        s.di.wreg_id          = rob_id_t'($random(seed));
        s.di.wmem             = wmem;
        s.di.msigned          = msigned;
        s.di.msize            = msize;
        s.opnd[OP_WDATA].data = $random(seed);
        s.opnd[OP_BASE].data  = $random(seed);
        // address split between base operand and immediate
        s.di.imm              = va - s.opnd[OP_BASE].data;
        for (int r = 0; r < REG_COUNT; r++) begin
            s.opnd[r].tag   = rob_id_t'($random(seed));
            s.opnd[r].valid = 1'b1;
            if (tag_en && ($random(seed) & 1)) begin
                s.opnd[r].tag   = tag_ctr;
                s.opnd[r].valid = 1'b0;
                tag_ctr++;
            end
        end
        pend_q.push_back(s);
    endfunction

    task automatic next_cycle();
        @(negedge clk);
        result_ready_i = !bp_en || (($random(seed) & 3) != 0);
        choose_i       = 2'b00;
        flush_i        = 1'b0;
        cdb_i          = '0;
    endtask

    task automatic send_slot(input int idx);
        disp_slot_t s;
        cdb_t       c;
        s = pend_q.pop_front();
        exp_q.push_back(ref_exec(s.di, s.opnd[OP_WDATA].data, s.opnd[OP_BASE].data));
        for (int r = 0; r < REG_COUNT; r++) begin
            if (!s.opnd[r].valid) begin
                c.valid  = 1'b1;
                c.rob_id = s.opnd[r].tag;
                c.data   = s.opnd[r].data;
                bcast_q.push_back(c);
                // the queue must take the broadcast value
                s.opnd[r].data = ~s.opnd[r].data;
            end
        end
        disp_i[idx] = s;
    endtask

    task automatic run_dispatch(input int max_cyc);
        int         n;
        logic [1:0] mask;
        n = 0;
        while ((pend_q.size() != 0 || bcast_q.size() != 0) && (max_cyc == 0 || n < max_cyc)) begin
            next_cycle();
            n++;
            mask = 2'($random(seed));
            if (mask == 2'b11 && pend_q.size() < 2) begin
                mask = 2'b01;
            end
            if (disp_ready_o && pend_q.size() != 0) begin
                choose_i = mask;
                // slot 0 gets the older one
                if (mask[0]) send_slot(0);
                if (mask[1]) send_slot(1);
            end
            for (int p = 0; p < CDB_COUNT; p++) begin
                if (bcast_q.size() != 0 && ($random(seed) & 1)) begin
                    cdb_i[p] = bcast_q.pop_front();
                end
            end
        end
    endtask

    task automatic drain();
        while (exp_q.size() != 0) begin
            next_cycle();
        end
    endtask

    function automatic word_t rand_addr();
        // only words 0 to 15 while the upper bits exercise the wrap
        return word_t'($random(seed)) & 32'hFFFF_FC3F;
    endfunction

    initial begin
        word_t va;
        seed           = 99;
        tag_ctr        = '0;
        tag_en         = 1'b0;
        bp_en          = 1'b0;
        rst_i          = 1'b1;
        flush_i        = 1'b0;
        disp_i         = '0;
        choose_i       = 2'b00;
        cdb_i          = '0;
        result_ready_i = 1'b1;
        repeat (5) @(posedge clk);
        @(negedge clk);
        rst_i = 1'b0;

        // known contents for every word that is loaded later
        for (int w = 0; w < N_INIT; w++) begin
            add_inst(1'b1, MSIZE_W, 1'b0, word_t'(4 * w));
        end
        run_dispatch(0);
        drain();

        // each store size into word 4 and then every load size and sign
        for (int k = 0; k < 3; k++) begin
            va = 32'd16 + (word_t'($random(seed)) & 32'd3 & ~((32'd1 << k) - 1));
            add_inst(1'b1, 2'(k), 1'b0, va);
            for (int l = 0; l < 6; l++) begin
                va = 32'd16 + (word_t'($random(seed)) & 32'd3 & ~((32'd1 << (l / 2)) - 1));
                add_inst(1'b0, 2'(l / 2), l[0], va);
            end
        end
        run_dispatch(0);
        drain();

        // random mix with tagged operands and result back-pressure
        tag_en = 1'b1;
        bp_en  = 1'b1;
        for (int i = 0; i < N_RAND; i++) begin
            add_inst(1'($random(seed)), 2'($unsigned($random(seed)) % 3),
                     1'($random(seed)), rand_addr());
        end
        run_dispatch(0);
        drain();

        // loads in flight when the flush hits
        for (int i = 0; i < N_FLUSH; i++) begin
            add_inst(1'b0, 2'($unsigned($random(seed)) % 3), 1'($random(seed)), rand_addr());
        end
        run_dispatch(8);
        next_cycle();
        flush_i = 1'b1;
        pend_q.delete();
        bcast_q.delete();
        next_cycle();
        if (!disp_ready_o || result_valid_o) begin
            fail_now("queue did not come back empty and ready after the flush");
        end

        // data stored before the flush must still be there
        for (int w = 0; w < N_INIT; w++) begin
            add_inst(1'b0, MSIZE_W, 1'b0, word_t'(4 * w));
        end
        for (int i = N_INIT; i < N_POST; i++) begin
            add_inst(1'($random(seed)), 2'($unsigned($random(seed)) % 3),
                     1'($random(seed)), rand_addr());
        end
        run_dispatch(0);
        drain();

        // idle a while so that any extra result shows up
        repeat (8) begin
            next_cycle();
        end

        if (exp_q.size() == 0 && !result_valid_o) begin
            $display("TESTS PASSED");
            $finish;
        end else begin
            fail_now("a result is still pending with nothing outstanding at the end of the run");
        end
    end

endmodule

//--- lsu_pipe.f
+incdir+test
hw/lsu_pkg.sv
hw/iq_entry.sv
hw/lsu_iq.sv
hw/lsu_agu.sv
hw/lsu_dmem.sv
hw/lsu_top.sv
test/tb_lsu_top.sv

//--- run.sh
#!/bin/sh
cd "$(dirname "$0")" || exit 1
verilator --binary --timing -Wno-fatal --top-module tb_lsu_top -f lsu_pipe.f -o sim_lsu \
    || { echo "verilator build failed"; exit 1; }
out=$(./obj_dir/sim_lsu 2>&1)
echo "$out"
echo "$out" | grep -q "^TESTS PASSED$" && exit 0 || exit 1
